//--- Makefile
# Verilator build and run of the Z80 I/O port block testbench

SRCS := $(wildcard *.sv *.svh)

obj_dir/Vtb_zports: project.f $(SRCS)
	verilator --binary --assert --top-module tb_zports -f project.f

run: obj_dir/Vtb_zports
	./obj_dir/Vtb_zports

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- io_port_map.sv
`timescale 1ns/1ps
////////////////////
// purely combinational decode of the low address byte
// #7FFD needs a15 low and the save ports exist in shadow mode only
////////////////////
module io_port_map
	import zport_pkg::*;
(
	input  z80_bus_t   bus,
	input  logic       shadow,
	input  logic [4:0] keys_in,
	input  logic       tape_read,
	input  logic [7:0] xt_rdata,
	input  logic [7:0] sys_rdata,
	output port_sel_e  sel,
	output logic       porthit,
	output logic       dataout,
	output logic [7:0] dout
);

	logic [7:0] loa;
	logic       sav_hit;

	assign loa = bus.addr[7:0];

	// #2F #4F #6F have a7 low, #8F has a7 high
	assign sav_hit = (loa[4:0] == SAVPORT_BASE[4:0]) && (loa[7] == (loa[6:5] == 2'b00));

	////////////////////
	// port class
	always_comb
	begin
		sel = SEL_NONE;
		if (loa == PORT_FE)
			sel = SEL_FE;
		else if (loa == PORT_XT)
			sel = SEL_XT;
		else if ((loa == PORT_FD) && !bus.addr[15])
			sel = SEL_7FFD;
		else if (loa == PORT_BF)
			sel = SEL_BF;
		else if (loa == PORT_BE)
			sel = SEL_BE;
		else if (sav_hit && shadow)
			sel = SEL_SAV;
	end

	assign porthit = (sel != SEL_NONE);
	assign dataout = porthit && !bus.iorq_n && !bus.rd_n; // we drive the data bus

	////////////////////
	// read data
	always_comb
	begin
		case (sel)
			SEL_FE:
				dout = {1'b1, tape_read, 1'b0, keys_in};
			SEL_XT:
				dout = xt_rdata;
			SEL_BF, SEL_BE, SEL_SAV:
				dout = sys_rdata;
			default:
				dout = 8'hFF; // #7FFD is write only
		endcase
	end

endmodule

//--- project.f
+incdir+.
zport_pkg.sv
z80_io_strobe.sv
io_port_map.sv
xt_regs.sv
sys_ctrl_regs.sv
zports_top.sv
tb_zports.sv

//--- sys_ctrl_regs.sv
`timescale 1ns/1ps
////////////////////
// #BF config bits, the save ports and the #BE readback
// #BE returns only the #7FFD byte (a11..a8 = #A) and #FF elsewhere
////////////////////
module sys_ctrl_regs
	import zport_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  logic       dos,
	input  port_cyc_t  cyc,
	input  logic [7:0] p7ffd,
	output logic       shadow,
	output logic       fnt_en,
	output logic       set_nmi,
	output logic [7:0] sys_rdata
);

	logic       shadow_en;
	logic [7:0] savport [4];
	logic       bf_wr;
	logic       sav_wr;

	assign bf_wr  = cyc.wr && (cyc.sel == SEL_BF);
	assign sav_wr = cyc.wr && (cyc.sel == SEL_SAV); // sel already needs shadow
	assign shadow = dos || shadow_en;

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			shadow_en <= 1'b0;
			fnt_en    <= 1'b0;
			set_nmi   <= 1'b0;
		end
		else if (bf_wr)
		begin
			shadow_en <= cyc.data[0];
			fnt_en    <= cyc.data[2]; // bit 1 (rom write) lives in memconf now
			set_nmi   <= cyc.data[3];
		end
	end

	always_ff @(posedge zclk)
	begin
		if (sav_wr)
			savport[cyc.lsub] <= cyc.data;
	end

	////////////////////
	// readback
	always_comb
	begin
		case (cyc.sel)
			SEL_BF:
				sys_rdata = {4'b0000, set_nmi, fnt_en, 1'b0, shadow_en};
			SEL_BE:
				sys_rdata = (cyc.hoa[3:0] == 4'hA) ? p7ffd : 8'hFF;
			SEL_SAV:
				sys_rdata = savport[cyc.lsub];
			default:
				sys_rdata = 8'hFF;
		endcase
	end

endmodule

//--- tb_tasks.svh
////////////////////
// included inside tb_zports and works on its signals and reference model
////////////////////
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic abort_run(input string why);
	begin
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped");
	end
endtask

////////////////////
// compare tasks
task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp)
		abort_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
endtask

task automatic check_mem_cfg(input string name, input mem_cfg_t got, input mem_cfg_t exp);
	if (got !== exp)
		abort_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
endtask

task automatic check_video_wr(input string name, input video_wr_t got, input video_wr_t exp);
	if (got !== exp)
		abort_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
endtask

function automatic mem_cfg_t expected_mem_cfg();
	mem_cfg_t m;
	m.xt_page     = exp_page;
	m.xt_override = exp_override;
	m.memconf     = exp_memconf;
	m.sysconf     = exp_sysconf;
	m.fmaddr      = exp_fmaddr;
	m.lock128     = (exp_memconf[7:6] == 2'b01);
	m.romrw_en    = exp_memconf[1];
	m.pent1m_rom  = exp_memconf[0];
	return m;
endfunction

////////////////////
// bus cycles
task automatic watch_clock();
	begin
		@(negedge zclk);
		video_seen = video_wr_t'(video_seen | video_wr);
		if (video_wr != '0)
			video_cycles++;
		if (!bus.iorq_n) // only while the cycle is active
		begin
			seen_dout    = dout;
			seen_hit     = porthit;
			seen_dataout = dataout;
		end
		@(posedge zclk);
	end
endtask

task automatic run_cycle(input z80_bus_t drive);
	begin
		video_seen   = '0;
		video_cycles = 0;
		@(posedge zclk);
		bus <= drive;
		repeat (4) watch_clock();
		bus <= BUS_IDLE; // iorq_n high for two clocks
		repeat (2) watch_clock();
	end
endtask

task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
	run_cycle(z80_bus_t'{addr: addr, din: data, iorq_n: 1'b0, rd_n: 1'b1, wr_n: 1'b0});
endtask

task automatic io_read(input logic [15:0] addr, output logic [7:0] data);
	begin
		run_cycle(z80_bus_t'{addr: addr, din: 8'hFF, iorq_n: 1'b0, rd_n: 1'b0, wr_n: 1'b1});
		data = seen_dout;
	end
endtask

task automatic xt_write(input xt_reg_e r, input logic [7:0] d);
	logic [7:0] num;
	begin
		num = r;
		case (r)
			RAMPAGE0, RAMPAGE1, RAMPAGE2, RAMPAGE3:
			begin
				exp_page[num[1:0]]     = d;
				exp_override[num[1:0]] = 1'b1;
			end
			XTOVERR: exp_override = d[3:0];
			FMADDR:  exp_fmaddr = d[4:0];
			SYSCONF: exp_sysconf = d;
			MEMCONF: exp_memconf = d;
			default: ;
		endcase
		io_write({r, PORT_XT}, d);
	end
endtask

task automatic p7ffd_write(input logic [7:0] d);
	begin
		if (!exp_7ffd[5]) // port closes itself with bit 5
		begin
			exp_7ffd       = d;
			exp_memconf[0] = d[4];
			exp_page[3]    = {3'b000, (exp_memconf[7:6] == 2'b01) ? 2'b00 : d[7:6], d[2:0]};
		end
		io_write(16'h7FFD, d);
	end
endtask

////////////////////
// directed tests
task automatic verify_reset_values();
	logic [7:0] d;
	begin
		io_read({RAMPAGE2, PORT_XT}, d);
		check_byte("xt rampage2", d, 8'h02);
		io_read({RAMPAGE3, PORT_XT}, d);
		check_byte("xt rampage3", d, 8'h00);
		io_read({8'h00, PORT_BF}, d);
		check_byte("bf config", d, 8'h00);
		check_mem_cfg("mem_cfg after reset", mem_cfg, expected_mem_cfg());
		check_byte("im2vect after reset", im2vect, 8'hFF);
		check_byte("set_nmi after reset", {7'd0, set_nmi}, 8'h00);
	end
endtask

task automatic ext_register_writes();
	xt_reg_e    pg [4];
	logic [7:0] d;
	begin
		pg = '{RAMPAGE0, RAMPAGE1, RAMPAGE2, RAMPAGE3};
		for (int i = 0; i < 4; i++)
		begin
			xt_write(pg[i], 8'($urandom()));
			check_mem_cfg("mem_cfg after page write", mem_cfg, expected_mem_cfg());
		end
		io_read({RAMPAGE3, PORT_XT}, d);
		check_byte("xt rampage3 readback", d, exp_page[3]);
		xt_write(XTOVERR, 8'h5A); // clears two of the four set bits
		check_mem_cfg("mem_cfg after override write", mem_cfg, expected_mem_cfg());
		xt_write(FMADDR, 8'($urandom()));
		xt_write(SYSCONF, 8'($urandom()));
		xt_write(MEMCONF, 8'($urandom()));
		d = 8'($urandom());
		xt_write(IM2VECT, d);
		check_byte("im2vect", im2vect, d);
		check_mem_cfg("mem_cfg after config writes", mem_cfg, expected_mem_cfg());
	end
endtask

task automatic paging_7ffd();
	logic [7:0] d;
	begin
		xt_write(MEMCONF, 8'h00);
		p7ffd_write(8'($urandom()) & 8'hDF); // bit 5 clear keeps it open
		check_mem_cfg("mem_cfg after 7ffd", mem_cfg, expected_mem_cfg());
		io_read(16'h7ABE, d);
		check_byte("be readback of 7ffd", d, exp_7ffd);
		io_read(16'h7BBE, d);
		check_byte("be other nibble", d, 8'hFF);
		xt_write(MEMCONF, 8'h40); // lock128
		p7ffd_write(8'hC7);
		check_mem_cfg("mem_cfg with lock128", mem_cfg, expected_mem_cfg());
		p7ffd_write(8'h23);
		p7ffd_write(8'h5C); // must be dropped
		check_mem_cfg("mem_cfg after 7ffd lock", mem_cfg, expected_mem_cfg());
		io_read(16'h7ABE, d);
		check_byte("be readback after lock", d, 8'h23);
	end
endtask

task automatic shadow_gating();
	logic [7:0] sav_addr [4];
	logic [7:0] sav_data [4];
	logic [7:0] d;
	begin
		sav_addr = '{8'h2F, 8'h4F, 8'h6F, 8'h8F};
		for (int i = 0; i < 4; i++)
		begin
			io_read({8'h00, sav_addr[i]}, d);
			check_byte("save port dout without shadow", d, 8'hFF);
			check_byte("save port porthit without shadow", {7'd0, seen_hit}, 8'h00);
		end
		io_write({8'h00, PORT_BF}, 8'h0D); // shadow_en, font write and nmi
		io_read({8'h00, PORT_BF}, d);
		check_byte("bf readback", d, 8'h0D);
		check_byte("fnt_en", {7'd0, fnt_en}, 8'h01);
		check_byte("set_nmi", {7'd0, set_nmi}, 8'h01);
		for (int i = 0; i < 4; i++)
		begin
			sav_data[i] = 8'($urandom());
			io_write({8'h00, sav_addr[i]}, sav_data[i]);
		end
		for (int i = 0; i < 4; i++)
		begin
			io_read({8'h00, sav_addr[i]}, d);
			check_byte("save port readback", d, sav_data[i]);
		end
	end
endtask

task automatic reads_and_strobes();
	video_wr_t  exp_vw;
	logic [7:0] d;
	begin
		keys_in   <= 5'($urandom());
		tape_read <= 1'b1;
		io_read({8'h00, PORT_FE}, d);
		check_byte("fe read", d, {1'b1, tape_read, 1'b0, keys_in});
		check_byte("dataout on fe read", {7'd0, seen_dataout}, 8'h01);
		exp_vw = '0;
		check_video_wr("video_wr on fe read", video_seen, exp_vw);
		io_write({8'h00, PORT_FE}, 8'h07);
		exp_vw.zborder = 1'b1;
		check_video_wr("video_wr on fe write", video_seen, exp_vw);
		check_byte("zborder pulse clocks", 8'(video_cycles), 8'd1);
		xt_write(VCONF, 8'($urandom()));
		exp_vw = '0;
		exp_vw.vconf = 1'b1;
		check_video_wr("video_wr on vconf write", video_seen, exp_vw);
		check_byte("vconf pulse clocks", 8'(video_cycles), 8'd1);
		io_read({XSTAT, PORT_XT}, d);
		check_byte("xt status read", d, 8'h00);
		check_byte("strobe clocks on xt read", 8'(video_cycles), 8'd0);
	end
endtask

`endif

//--- tb_zports.sv
`timescale 1ns/1ps
////////////////////
// directed testbench for zports_top, one Z80 I/O cycle takes 7 zclk here
// any failed check or the cycle limit stops the run through $fatal
////////////////////
module tb_zports
	import zport_pkg::*;
();

	// about 40 bus cycles of 7 clocks plus reset with wide margin on top
	localparam int CYCLE_LIMIT = 2000;
	localparam z80_bus_t BUS_IDLE = '{addr: 16'h0000, din: 8'h00,
		iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1};

	logic       zclk;
	logic       rst_n;
	z80_bus_t   bus;
	logic       dos;
	logic [4:0] keys_in;
	logic       tape_read;
	logic [7:0] dout;
	logic       dataout;
	logic       porthit;
	video_wr_t  video_wr;
	mem_cfg_t   mem_cfg;
	logic [7:0] im2vect;
	logic       fnt_en;
	logic       set_nmi;
	int         cycle_cnt = 0;

	////////////////////
	// what the last bus cycle showed
	video_wr_t  video_seen;  // OR of all strobes
	int         video_cycles; // clocks with any strobe high
	logic [7:0] seen_dout;
	logic       seen_hit;
	logic       seen_dataout;

	////////////////////
	// reference model of the registers
	logic [3:0][7:0] exp_page;
	logic [3:0]      exp_override;
	logic [7:0]      exp_memconf;
	logic [7:0]      exp_sysconf;
	logic [4:0]      exp_fmaddr;
	logic [7:0]      exp_7ffd;

	zports_top i_dut (
		.zclk      (zclk),
		.rst_n     (rst_n),
		.bus       (bus),
		.dos       (dos),
		.keys_in   (keys_in),
		.tape_read (tape_read),
		.dout      (dout),
		.dataout   (dataout),
		.porthit   (porthit),
		.video_wr  (video_wr),
		.mem_cfg   (mem_cfg),
		.im2vect   (im2vect),
		.fnt_en    (fnt_en),
		.set_nmi   (set_nmi)
	);

	`include "tb_tasks.svh"

	initial
	begin
		zclk = 1'b0;
		forever #4 zclk = ~zclk;
	end

	always @(posedge zclk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
			abort_run("timeout: test sequence did not finish within the cycle limit");
	end

	initial
	begin
		void'($urandom(17128));
		rst_n        = 1'b0;
		bus          = BUS_IDLE;
		dos          = 1'b0;
		keys_in      = 5'd0;
		tape_read    = 1'b0;
		video_seen   = '0;
		video_cycles = 0;
		// reset state as the port block defines it
		exp_page     = {8'h00, 8'h02, 8'h05, 8'h00};
		exp_override = 4'b0000;
		exp_memconf  = 8'h00;
		exp_sysconf  = 8'h01;
		exp_fmaddr   = 5'd0;
		exp_7ffd     = 8'h00;
		repeat (5) @(posedge zclk);
		rst_n <= 1'b1;

		verify_reset_values();
		ext_register_writes();
		paging_7ffd();
		shadow_gating();
		reads_and_strobes();

		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- xt_regs.sv
`timescale 1ns/1ps
////////////////////
// extension register file, #7FFD paging and video write strobes
// #7FFD locks itself once bit 5 is written and stays locked until reset
////////////////////
module xt_regs
	import zport_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  port_cyc_t  cyc,
	output mem_cfg_t   mem_cfg,
	output logic [7:0] im2vect,
	output video_wr_t  video_wr,
	output logic [7:0] p7ffd,
	output logic [7:0] xt_rdata
);

	logic [3:0][7:0] rampage;
	logic [3:0]      xt_override;
	logic [4:0]      fmaddr;
	logic [7:0]      sysconf;
	logic [7:0]      memconf;
	logic            lock128;
	logic            xt_wr;
	logic            p7ffd_wr;

	assign lock128  = (memconf[7:6] == 2'b01);
	assign xt_wr    = cyc.wr && (cyc.sel == SEL_XT);
	assign p7ffd_wr = cyc.wr && (cyc.sel == SEL_7FFD) && !p7ffd[5];

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			rampage     <= RST_RAMPAGE;
			xt_override <= 4'b0000;
			fmaddr      <= 5'd0;
			sysconf     <= RST_SYSCONF;
			memconf     <= RST_MEMCONF;
			im2vect     <= RST_IM2VECT;
			p7ffd       <= 8'h00;
		end
		else if (p7ffd_wr)
		begin
			p7ffd      <= cyc.data;
			memconf[0] <= cyc.data[4]; // rom select
			rampage[3] <= {3'b000, lock128 ? 2'b00 : cyc.data[7:6], cyc.data[2:0]};
		end
		else if (xt_wr)
		begin
			if (cyc.hoa inside {RAMPAGE0, RAMPAGE1, RAMPAGE2, RAMPAGE3})
			begin
				rampage[cyc.hoa[1:0]]     <= cyc.data;
				xt_override[cyc.hoa[1:0]] <= 1'b1; // page now owned by XT
			end
			if (cyc.hoa == XTOVERR)
				xt_override <= cyc.data[3:0];
			if (cyc.hoa == FMADDR)
				fmaddr <= cyc.data[4:0];
			if (cyc.hoa == SYSCONF)
				sysconf <= cyc.data;
			if (cyc.hoa == MEMCONF)
				memconf <= cyc.data;
			if (cyc.hoa == IM2VECT)
				im2vect <= cyc.data;
		end
	end

	assign mem_cfg = '{xt_page: rampage, xt_override: xt_override, memconf: memconf,
		sysconf: sysconf, fmaddr: fmaddr, lock128: lock128, romrw_en: memconf[1],
		pent1m_rom: memconf[0]};

	////////////////////
	// strobes to the video block
	always_comb
	begin
		video_wr.zborder = cyc.wr && (cyc.sel == SEL_FE);
		video_wr.border  = xt_wr && (cyc.hoa == XBORDER);
		video_wr.vconf   = xt_wr && (cyc.hoa == VCONF);
		video_wr.vpage   = xt_wr && (cyc.hoa == VPAGE);
		video_wr.palsel  = xt_wr && (cyc.hoa == PALSEL);
		video_wr.zvpage  = p7ffd_wr;
	end

	always_comb
	begin
		case (cyc.hoa)
			XSTAT:    xt_rdata = 8'h00; // nothing busy here
			RAMPAGE2: xt_rdata = rampage[2];
			RAMPAGE3: xt_rdata = rampage[3];
			default:  xt_rdata = 8'hFF;
		endcase
	end

	a_reset_hold: assert property (@(posedge zclk)
		(!rst_n ##1 !rst_n) |=> $stable({mem_cfg, im2vect, p7ffd}));

endmodule

//--- z80_io_strobe.sv
`timescale 1ns/1ps
////////////////////
// Z80 must hold iorq_n low for at least three zclk edges per cycle
// cycle fields follow the live bus so they are valid only while the cycle lasts
////////////////////
module z80_io_strobe
	import zport_pkg::*;
(
	input  logic      zclk,
	input  logic      rst_n,
	input  z80_bus_t  bus,
	input  port_sel_e sel,
	output port_cyc_t cyc
);

	logic iowr;
	logic iord;
	logic iowr_s; // first sample of the cycle
	logic iord_s;
	logic iowr_d;
	logic iord_d;
	logic wr_q;
	logic rd_q;

	assign iowr = !bus.iorq_n && !bus.wr_n;
	assign iord = !bus.iorq_n && !bus.rd_n;

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			iowr_s <= 1'b0;
			iord_s <= 1'b0;
			iowr_d <= 1'b0;
			iord_d <= 1'b0;
			wr_q   <= 1'b0;
			rd_q   <= 1'b0;
		end
		else
		begin
			iowr_s <= iowr;
			iord_s <= iord;
			iowr_d <= iowr_s;
			iord_d <= iord_s;
			wr_q   <= iowr_s && !iowr_d; // rising edge only
			rd_q   <= iord_s && !iord_d;
		end
	end

	assign cyc = '{sel: sel, hoa: bus.addr[15:8], lsub: bus.addr[6:5], data: bus.din,
		wr: wr_q, rd: rd_q};

	a_wr_rd_excl: assert property (@(posedge zclk) disable iff (!rst_n) !(wr_q && rd_q));
	a_wr_single: assert property (@(posedge zclk) disable iff (!rst_n) wr_q |=> !wr_q);
	a_rd_single: assert property (@(posedge zclk) disable iff (!rst_n) rd_q |=> !rd_q);

endmodule

//--- zport_pkg.sv
////////////////////
// port addresses, extension register numbers and bus types of the Z80 I/O block
// reset values give turbo 7 MHz and ATM memory mode with no page override
////////////////////
package zport_pkg;

	////////////////////
	// port low bytes
	localparam logic [7:0] PORT_FE      = 8'hFE; // keyboard, tape, border
	localparam logic [7:0] PORT_XT      = 8'hAF; // extension port #nnAF
	localparam logic [7:0] PORT_FD      = 8'hFD; // #7FFD with a15 low
	localparam logic [7:0] PORT_BF      = 8'hBF;
	localparam logic [7:0] PORT_BE      = 8'hBE;
	localparam logic [7:0] SAVPORT_BASE = 8'h0F; // low nibble pattern of #2F/#4F/#6F/#8F

	////////////////////
	// extension register numbers, matched against the high address byte
	typedef enum logic [7:0] {
		VCONF    = 8'h00,
		VPAGE    = 8'h01,
		PALSEL   = 8'h07,
		XBORDER  = 8'h0F,
		RAMPAGE0 = 8'h10,
		RAMPAGE1 = 8'h11,
		RAMPAGE2 = 8'h12,
		RAMPAGE3 = 8'h13,
		FMADDR   = 8'h15,
		SYSCONF  = 8'h20,
		MEMCONF  = 8'h21,
		IM2VECT  = 8'h25,
		XTOVERR  = 8'h2A
	} xt_reg_e;

	// status shares #00 with VCONF and is seen on reads only
	localparam xt_reg_e XSTAT = VCONF;

	typedef enum logic [2:0] {
		SEL_NONE,
		SEL_FE,
		SEL_XT,
		SEL_7FFD,
		SEL_BF,
		SEL_BE,
		SEL_SAV
	} port_sel_e;

	////////////////////
	// bundles
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  din;
		logic        iorq_n;
		logic        rd_n;
		logic        wr_n;
	} z80_bus_t;

	typedef struct packed {
		port_sel_e   sel;
		logic [7:0]  hoa;  // a15..a8
		logic [1:0]  lsub; // a6..a5 for the save ports
		logic [7:0]  data;
		logic        wr;   // one zclk per I/O write
		logic        rd;   // one zclk per I/O read
	} port_cyc_t;

	typedef struct packed {
		logic zborder;
		logic border;
		logic vconf;
		logic vpage;
		logic palsel;
		logic zvpage;
	} video_wr_t;

	typedef struct packed {
		logic [31:0] xt_page;     // page 3 in the top byte
		logic [3:0]  xt_override;
		logic [7:0]  memconf;
		logic [7:0]  sysconf;
		logic [4:0]  fmaddr;
		logic        lock128;
		logic        romrw_en;
		logic        pent1m_rom;
	} mem_cfg_t;

	localparam logic [7:0]  RST_SYSCONF = 8'h01;
	localparam logic [7:0]  RST_MEMCONF = 8'h00;
	localparam logic [7:0]  RST_IM2VECT = 8'hFF;
	localparam logic [31:0] RST_RAMPAGE = 32'h00_02_05_00;

endpackage

//--- zports_top.sv
`timescale 1ns/1ps
////////////////////
// Z80 I/O port block, single zclk domain
////////////////////
module zports_top
	import zport_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  z80_bus_t   bus,
	input  logic       dos,
	input  logic [4:0] keys_in,
	input  logic       tape_read,
	output logic [7:0] dout,
	output logic       dataout,
	output logic       porthit,
	output video_wr_t  video_wr,
	output mem_cfg_t   mem_cfg,
	output logic [7:0] im2vect,
	output logic       fnt_en,
	output logic       set_nmi
);

	port_sel_e  sel;
	port_cyc_t  cyc;
	logic       shadow;
	logic [7:0] xt_rdata;
	logic [7:0] sys_rdata;
	logic [7:0] p7ffd;

	z80_io_strobe i_strobe (
		.zclk  (zclk),
		.rst_n (rst_n),
		.bus   (bus),
		.sel   (sel),
		.cyc   (cyc)
	);

	io_port_map i_map (
		.bus       (bus),
		.shadow    (shadow),
		.keys_in   (keys_in),
		.tape_read (tape_read),
		.xt_rdata  (xt_rdata),
		.sys_rdata (sys_rdata),
		.sel       (sel),
		.porthit   (porthit),
		.dataout   (dataout),
		.dout      (dout)
	);

	xt_regs i_xt (
		.zclk     (zclk),
		.rst_n    (rst_n),
		.cyc      (cyc),
		.mem_cfg  (mem_cfg),
		.im2vect  (im2vect),
		.video_wr (video_wr),
		.p7ffd    (p7ffd),
		.xt_rdata (xt_rdata)
	);

	sys_ctrl_regs i_sys (
		.zclk      (zclk),
		.rst_n     (rst_n),
		.dos       (dos),
		.cyc       (cyc),
		.p7ffd     (p7ffd),
		.shadow    (shadow),
		.fnt_en    (fnt_en),
		.set_nmi   (set_nmi),
		.sys_rdata (sys_rdata)
	);

endmodule
